//--- logic/stq_pkg.sv
//######################################################################
// store queue package
// depth, field widths and the typedefs shared by the queue blocks
//######################################################################
`default_nettype none

package stq_pkg;

  localparam int STQ_DEPTH = 8;
  localparam int IDX_W = 3;
  // occupancy needs one more bit than an index
  localparam int CNT_W = IDX_W + 1;
  localparam int ADDR_W = 12;
  localparam int BYTES_W = 4;
  localparam int DATA_W = 32;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [STQ_DEPTH-1:0] entry_vec_t;
  typedef logic [CNT_W-1:0] cnt_t;
  // word-aligned line address
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BYTES_W-1:0] byte_mask_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

//--- logic/stq_alloc.sv
//######################################################################
// store queue allocator
// keeps head, commit and tail pointers in program order and gates
// the store, commit and free strobes against the queue state
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_alloc
  import stq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       store_en,
  input  logic       commit_en,
  input  logic       free_en,
  output entry_vec_t wrt_en,
  output entry_vec_t commit_vec,
  output entry_vec_t free_vec,
  output idx_t       tail_idx,
  output logic       full
);

  idx_t head_ptr;
  idx_t cmt_ptr;
  idx_t tail_ptr;
  // allocated entries, and the part of them not yet committed
  cnt_t count;
  cnt_t ucnt;

  logic acc_store;
  logic acc_commit;
  logic acc_free;

  assign full = (count == CNT_W'(STQ_DEPTH));

  assign acc_store = store_en && !full;
  assign acc_commit = commit_en && (ucnt != '0);
  // head is committed whenever any committed entry exists
  assign acc_free = free_en && (count != ucnt);

  assign wrt_en = acc_store ? (entry_vec_t'(1) << tail_ptr) : '0;
  assign commit_vec = acc_commit ? (entry_vec_t'(1) << cmt_ptr) : '0;
  assign free_vec = acc_free ? (entry_vec_t'(1) << head_ptr) : '0;

  assign tail_idx = tail_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      cmt_ptr <= '0;
      tail_ptr <= '0;
      count <= '0;
      ucnt <= '0;
    end else begin
      if (acc_store) begin
        tail_ptr <= tail_ptr + idx_t'(1);
      end
      if (acc_commit) begin
        cmt_ptr <= cmt_ptr + idx_t'(1);
      end
      if (acc_free) begin
        head_ptr <= head_ptr + idx_t'(1);
      end
      count <= count + cnt_t'(acc_store) - cnt_t'(acc_free);
      ucnt <= ucnt + cnt_t'(acc_store) - cnt_t'(acc_commit);
    end
  end

  // commit pointer stays between head and tail
  a_cmt_in_range: assert property (
    @(posedge clk) disable iff (rst)
    (ucnt <= count) && (idx_t'(tail_ptr - cmt_ptr) == idx_t'(ucnt))
  ) else $error("commit pointer ran past the tail");

  // a store offered while full is dropped
  a_store_full: assert property (
    @(posedge clk) disable iff (rst)
    full |-> !store_en
  ) else $warning("store_en while full, store dropped");

endmodule

`default_nettype wire

//--- logic/stq_entry.sv
//######################################################################
// store queue entry
// address, byte mask, data and state bits of one in-flight store,
// with the compare logic for both load check ports
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_entry
  import stq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       wrt_en,
  input  addr_t      wrt_addr,
  input  byte_mask_t wrt_bytes,
  input  logic       upd_en,
  input  data_t      upd_data,
  input  logic       commit_en,
  input  logic       free_en,
  input  logic       chk0_en,
  input  addr_t      chk0_addr,
  input  byte_mask_t chk0_bytes,
  input  logic       chk1_en,
  input  addr_t      chk1_addr,
  input  byte_mask_t chk1_bytes,
  output logic       chk0_match,
  output logic       chk0_partial,
  output logic       chk1_match,
  output logic       chk1_partial,
  output data_t      data
);

  addr_t      addr_q;
  byte_mask_t bytes_q;
  data_t      data_q;
  logic       free_q;
  logic       ready_q;
  logic       cmt_q;

  // {match, partial} for one load against this entry
  function automatic logic [1:0] check(input logic en, input addr_t a,
                                       input byte_mask_t b);
    logic overlap;
    logic covered;
    overlap = en && !free_q && !cmt_q && (a == addr_q) && ((b & bytes_q) != '0);
    covered = ((b & ~bytes_q) == '0);
    return {overlap && covered && ready_q, overlap && (!covered || !ready_q)};
  endfunction

  always_comb begin
    {chk0_match, chk0_partial} = check(chk0_en, chk0_addr, chk0_bytes);
    {chk1_match, chk1_partial} = check(chk1_en, chk1_addr, chk1_bytes);
  end

  assign data = data_q;

  // later strobes win in the order write, update, commit, free
  always_ff @(posedge clk) begin
    if (rst) begin
      free_q <= 1'b1;
      ready_q <= 1'b1;
      cmt_q <= 1'b0;
    end else begin
      if (wrt_en) begin
        free_q <= 1'b0;
        ready_q <= 1'b0;
        cmt_q <= 1'b0;
      end
      if (upd_en) begin
        ready_q <= 1'b1;
      end
      if (commit_en) begin
        cmt_q <= 1'b1;
      end
      if (free_en) begin
        free_q <= 1'b1;
        cmt_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrt_en) begin
      addr_q <= wrt_addr;
      bytes_q <= wrt_bytes;
    end
    if (upd_en) begin
      data_q <= upd_data;
    end
  end

  a_wrt_free: assert property (
    @(posedge clk) disable iff (rst)
    wrt_en |-> free_q
  ) else $error("write to an entry still in use");

  a_free_cmt: assert property (
    @(posedge clk) disable iff (rst)
    free_en |-> cmt_q
  ) else $error("free of an uncommitted entry");

endmodule

`default_nettype wire

//--- logic/stq_entry_array.sv
//######################################################################
// store queue entry array
// eight entries sharing the store, data and load check buses
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_entry_array
  import stq_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  entry_vec_t              wrt_en,
  input  addr_t                   store_addr,
  input  byte_mask_t              store_bytes,
  input  logic                    data_en,
  input  idx_t                    data_idx,
  input  data_t                   data_val,
  input  entry_vec_t              commit_vec,
  input  entry_vec_t              free_vec,
  input  logic                    chk0_en,
  input  addr_t                   chk0_addr,
  input  byte_mask_t              chk0_bytes,
  input  logic                    chk1_en,
  input  addr_t                   chk1_addr,
  input  byte_mask_t              chk1_bytes,
  output entry_vec_t              chk0_match,
  output entry_vec_t              chk0_partial,
  output entry_vec_t              chk1_match,
  output entry_vec_t              chk1_partial,
  output data_t [STQ_DEPTH-1:0]   entry_data
);

  entry_vec_t upd_vec;

  assign upd_vec = data_en ? (entry_vec_t'(1) << data_idx) : '0;

  for (genvar e = 0; e < STQ_DEPTH; e++) begin : g_entry
    stq_entry u_entry (
      .clk          (clk),
      .rst          (rst),
      .wrt_en       (wrt_en[e]),
      .wrt_addr     (store_addr),
      .wrt_bytes    (store_bytes),
      .upd_en       (upd_vec[e]),
      .upd_data     (data_val),
      .commit_en    (commit_vec[e]),
      .free_en      (free_vec[e]),
      .chk0_en      (chk0_en),
      .chk0_addr    (chk0_addr),
      .chk0_bytes   (chk0_bytes),
      .chk1_en      (chk1_en),
      .chk1_addr    (chk1_addr),
      .chk1_bytes   (chk1_bytes),
      .chk0_match   (chk0_match[e]),
      .chk0_partial (chk0_partial[e]),
      .chk1_match   (chk1_match[e]),
      .chk1_partial (chk1_partial[e]),
      .data         (entry_data[e])
    );
  end

endmodule

`default_nettype wire

//--- logic/stq_fwd_select.sv
//######################################################################
// forward selector
// picks the youngest overlapping store for one load check port and
// registers hit, replay or miss
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_fwd_select
  import stq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  chk_en,
  input  entry_vec_t            match,
  input  entry_vec_t            partial,
  input  idx_t                  tail_idx,
  input  data_t [STQ_DEPTH-1:0] entry_data,
  output logic                  hit,
  output logic                  replay,
  output idx_t                  idx,
  output data_t                 data
);

  logic [2*STQ_DEPTH-1:0] match2;
  logic [2*STQ_DEPTH-1:0] partial2;
  entry_vec_t rot_match;
  entry_vec_t rot_partial;

  logic sel_hit;
  logic sel_replay;
  idx_t sel_idx;

  // rotate so bit 7 is the entry just below the tail, the youngest
  assign match2 = {match, match} >> tail_idx;
  assign partial2 = {partial, partial} >> tail_idx;
  assign rot_match = match2[STQ_DEPTH-1:0];
  assign rot_partial = partial2[STQ_DEPTH-1:0];

  // ascending scan, so the highest set position wins
  always_comb begin
    sel_hit = 1'b0;
    sel_replay = 1'b0;
    sel_idx = '0;
    for (int j = 0; j < STQ_DEPTH; j++) begin
      if (rot_match[j] || rot_partial[j]) begin
        sel_hit = rot_match[j];
        sel_replay = !rot_match[j];
        sel_idx = idx_t'(j) + tail_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
      replay <= 1'b0;
      idx <= '0;
      data <= '0;
    end else begin
      hit <= chk_en && sel_hit;
      replay <= chk_en && sel_replay;
      idx <= (chk_en && sel_hit) ? sel_idx : '0;
      data <= (chk_en && sel_hit) ? entry_data[sel_idx] : '0;
    end
  end

  // the chosen index maps back to an entry that matched
  a_hit_matched: assert property (
    @(posedge clk) disable iff (rst)
    hit |-> $past(match[sel_idx])
  ) else $error("hit on an entry that did not match");

endmodule

`default_nettype wire

//--- logic/stq_top.sv
//######################################################################
// store queue top
// allocator, entry array and a forward selector per load check port
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_top
  import stq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       store_en,
  input  addr_t      store_addr,
  input  byte_mask_t store_bytes,
  input  logic       data_en,
  input  idx_t       data_idx,
  input  data_t      data_val,
  input  logic       commit_en,
  input  logic       free_en,
  input  logic       ld0_en,
  input  addr_t      ld0_addr,
  input  byte_mask_t ld0_bytes,
  input  logic       ld1_en,
  input  addr_t      ld1_addr,
  input  byte_mask_t ld1_bytes,
  output idx_t       store_idx,
  output logic       full,
  output logic       ld0_hit,
  output logic       ld0_replay,
  output idx_t       ld0_idx,
  output data_t      ld0_data,
  output logic       ld1_hit,
  output logic       ld1_replay,
  output idx_t       ld1_idx,
  output data_t      ld1_data
);

  entry_vec_t wrt_en;
  entry_vec_t commit_vec;
  entry_vec_t free_vec;
  idx_t       tail_idx;

  entry_vec_t chk0_match;
  entry_vec_t chk0_partial;
  entry_vec_t chk1_match;
  entry_vec_t chk1_partial;
  data_t [STQ_DEPTH-1:0] entry_data;

  // next store lands at the tail
  assign store_idx = tail_idx;

  stq_alloc u_alloc (
    .clk        (clk),
    .rst        (rst),
    .store_en   (store_en),
    .commit_en  (commit_en),
    .free_en    (free_en),
    .wrt_en     (wrt_en),
    .commit_vec (commit_vec),
    .free_vec   (free_vec),
    .tail_idx   (tail_idx),
    .full       (full)
  );

  stq_entry_array u_array (
    .clk          (clk),
    .rst          (rst),
    .wrt_en       (wrt_en),
    .store_addr   (store_addr),
    .store_bytes  (store_bytes),
    .data_en      (data_en),
    .data_idx     (data_idx),
    .data_val     (data_val),
    .commit_vec   (commit_vec),
    .free_vec     (free_vec),
    .chk0_en      (ld0_en),
    .chk0_addr    (ld0_addr),
    .chk0_bytes   (ld0_bytes),
    .chk1_en      (ld1_en),
    .chk1_addr    (ld1_addr),
    .chk1_bytes   (ld1_bytes),
    .chk0_match   (chk0_match),
    .chk0_partial (chk0_partial),
    .chk1_match   (chk1_match),
    .chk1_partial (chk1_partial),
    .entry_data   (entry_data)
  );

  stq_fwd_select u_fwd0 (
    .clk        (clk),
    .rst        (rst),
    .chk_en     (ld0_en),
    .match      (chk0_match),
    .partial    (chk0_partial),
    .tail_idx   (tail_idx),
    .entry_data (entry_data),
    .hit        (ld0_hit),
    .replay     (ld0_replay),
    .idx        (ld0_idx),
    .data       (ld0_data)
  );

  stq_fwd_select u_fwd1 (
    .clk        (clk),
    .rst        (rst),
    .chk_en     (ld1_en),
    .match      (chk1_match),
    .partial    (chk1_partial),
    .tail_idx   (tail_idx),
    .entry_data (entry_data),
    .hit        (ld1_hit),
    .replay     (ld1_replay),
    .idx        (ld1_idx),
    .data       (ld1_data)
  );

endmodule

`default_nettype wire

//--- bench/stq_tb.sv
//######################################################################
// store queue testbench
// table of stores, data, commits, frees and load pairs checked
// against a shadow queue, followed by random load checks
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module stq_tb
  import stq_pkg::*;
();

  typedef enum logic [2:0] {
    OP_IDLE, OP_STORE, OP_DATA, OP_COMMIT, OP_FREE, OP_LOAD, OP_WAIT
  } op_kind_t;

  // a0/b0 also carry the store fields
  // a load port with b == 0 is off
  typedef struct packed {
    op_kind_t   kind;
    idx_t       idx;
    addr_t      a0;
    byte_mask_t b0;
    addr_t      a1;
    byte_mask_t b1;
    data_t      val;
  } op_t;

  logic clk;
  logic rst;
  logic store_en, data_en, commit_en, free_en, ld0_en, ld1_en;
  addr_t store_addr, ld0_addr, ld1_addr;
  byte_mask_t store_bytes, ld0_bytes, ld1_bytes;
  idx_t data_idx, store_idx, ld0_idx, ld1_idx;
  data_t data_val, ld0_data, ld1_data;
  logic full, ld0_hit, ld0_replay, ld1_hit, ld1_replay;

  // shadow queue
  logic       m_free[STQ_DEPTH];
  logic       m_ready[STQ_DEPTH];
  logic       m_cmt[STQ_DEPTH];
  addr_t      m_addr[STQ_DEPTH];
  byte_mask_t m_bytes[STQ_DEPTH];
  data_t      m_data[STQ_DEPTH];
  idx_t       m_head, m_cptr, m_tail;
  int         m_count, m_ucnt;

  logic  exp_hit[2];
  logic  exp_rep[2];
  idx_t  exp_idx[2];
  data_t exp_data[2];

  op_t    ops[$];
  integer seed;
  addr_t  addr_pool[4] = '{12'h040, 12'h050, 12'h060, 12'h0ff};

  stq_top u_stq_top (
    .clk(clk), .rst(rst),
    .store_en(store_en), .store_addr(store_addr), .store_bytes(store_bytes),
    .data_en(data_en), .data_idx(data_idx), .data_val(data_val),
    .commit_en(commit_en), .free_en(free_en),
    .ld0_en(ld0_en), .ld0_addr(ld0_addr), .ld0_bytes(ld0_bytes),
    .ld1_en(ld1_en), .ld1_addr(ld1_addr), .ld1_bytes(ld1_bytes),
    .store_idx(store_idx), .full(full),
    .ld0_hit(ld0_hit), .ld0_replay(ld0_replay), .ld0_idx(ld0_idx), .ld0_data(ld0_data),
    .ld1_hit(ld1_hit), .ld1_replay(ld1_replay), .ld1_idx(ld1_idx), .ld1_data(ld1_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string name, input idx_t got, input idx_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic void push_op(input op_kind_t k, input idx_t i, input addr_t a0,
                                  input byte_mask_t b0, input addr_t a1,
                                  input byte_mask_t b1, input data_t v);
    op_t op;
    op = '{kind: k, idx: i, a0: a0, b0: b0, a1: a1, b1: b1, val: v};
    ops.push_back(op);
  endfunction

  // youngest first from tail - 1, first overlap decides
  task automatic predict(input int p, input logic en, input addr_t a, input byte_mask_t b);
    idx_t e;
    logic found;
    found = 1'b0;
    exp_hit[p] = 1'b0;
    exp_rep[p] = 1'b0;
    exp_idx[p] = '0;
    exp_data[p] = '0;
    for (int k = 1; k <= STQ_DEPTH; k++) begin
      e = idx_t'(m_tail - idx_t'(k));
      if (en && !found && !m_free[e] && !m_cmt[e] && m_addr[e] == a &&
          (m_bytes[e] & b) != '0) begin
        found = 1'b1;
        if (m_ready[e] && (b & ~m_bytes[e]) == '0) begin
          exp_hit[p] = 1'b1;
          exp_idx[p] = e;
          exp_data[p] = m_data[e];
        end else begin
          exp_rep[p] = 1'b1;
        end
      end
    end
  endtask

  task automatic update_model(input op_t op);
    case (op.kind)
      OP_STORE: if (m_count < STQ_DEPTH) begin
        m_addr[m_tail] = op.a0;
        m_bytes[m_tail] = op.b0;
        m_free[m_tail] = 1'b0;
        m_ready[m_tail] = 1'b0;
        m_cmt[m_tail] = 1'b0;
        m_tail = m_tail + idx_t'(1);
        m_count++;
        m_ucnt++;
      end
      OP_DATA: begin
        m_ready[op.idx] = 1'b1;
        m_data[op.idx] = op.val;
      end
      OP_COMMIT: if (m_ucnt > 0) begin
        m_cmt[m_cptr] = 1'b1;
        m_cptr = m_cptr + idx_t'(1);
        m_ucnt--;
      end
      OP_FREE: if (!m_free[m_head] && m_cmt[m_head]) begin
        m_free[m_head] = 1'b1;
        m_cmt[m_head] = 1'b0;
        m_head = m_head + idx_t'(1);
        m_count--;
      end
      default: ;
    endcase
  endtask

  task automatic apply_op(input op_t op);
    store_en = (op.kind == OP_STORE);
    store_addr = op.a0;
    store_bytes = op.b0;
    data_en = (op.kind == OP_DATA);
    data_idx = op.idx;
    data_val = op.val;
    commit_en = (op.kind == OP_COMMIT);
    free_en = (op.kind == OP_FREE);
    ld0_en = (op.kind == OP_LOAD) && (op.b0 != '0);
    ld0_addr = op.a0;
    ld0_bytes = op.b0;
    ld1_en = (op.kind == OP_LOAD) && (op.b1 != '0);
    ld1_addr = op.a1;
    ld1_bytes = op.b1;
    predict(0, ld0_en, op.a0, op.b0);
    predict(1, ld1_en, op.a1, op.b1);
    update_model(op);
  endtask

  task automatic wait_room();
    int n;
    n = 0;
    while (full) begin
      @(negedge clk);
      n++;
      if (n > 50) begin
        $display("timeout: full stayed high after a commit and a free");
        abort_run();
      end
    end
  endtask

  task automatic check_results();
    check_flag("ld0_hit", ld0_hit, exp_hit[0]);
    check_flag("ld0_replay", ld0_replay, exp_rep[0]);
    check_idx("ld0_idx", ld0_idx, exp_idx[0]);
    check_data("ld0_data", ld0_data, exp_data[0]);
    check_flag("ld1_hit", ld1_hit, exp_hit[1]);
    check_flag("ld1_replay", ld1_replay, exp_rep[1]);
    check_idx("ld1_idx", ld1_idx, exp_idx[1]);
    check_data("ld1_data", ld1_data, exp_data[1]);
  endtask

  task automatic step(input op_t op);
    @(negedge clk);
    check_results();
    check_flag("full", full, m_count == STQ_DEPTH);
    check_idx("store_idx", store_idx, m_tail);
    apply_op(op);
    if (op.kind == OP_WAIT) begin
      wait_room();
    end
  endtask

  initial begin
    op_t op;
    seed = 32'h9d2d;
    for (int e = 0; e < STQ_DEPTH; e++) begin
      m_free[e] = 1'b1;
      m_ready[e] = 1'b1;
      m_cmt[e] = 1'b0;
      m_addr[e] = '0;
      m_bytes[e] = '0;
      m_data[e] = '0;
    end
    m_head = '0;
    m_cptr = '0;
    m_tail = '0;
    m_count = 0;
    m_ucnt = 0;
    rst = 1'b1;
    op = '{kind: OP_IDLE, idx: '0, a0: '0, b0: '0, a1: '0, b1: '0, val: '0};
    apply_op(op);

    // forwarding and miss
    push_op(OP_STORE, 3'd0, 12'h010, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h1111_0000);
    push_op(OP_LOAD, 3'd0, 12'h010, 4'hf, 12'h020, 4'hf, 32'h0);
    // data not yet arrived, then a load wider than the store
    push_op(OP_STORE, 3'd0, 12'h030, 4'h3, 12'h000, 4'h0, 32'h0);
    push_op(OP_LOAD, 3'd0, 12'h030, 4'h1, 12'h030, 4'hc, 32'h0);
    push_op(OP_DATA, 3'd1, 12'h000, 4'h0, 12'h000, 4'h0, 32'h2222_3333);
    push_op(OP_LOAD, 3'd0, 12'h030, 4'h1, 12'h030, 4'h7, 32'h0);
    // youngest overlap wins, ports independent
    push_op(OP_STORE, 3'd0, 12'h010, 4'h3, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd2, 12'h000, 4'h0, 12'h000, 4'h0, 32'haaaa_bbbb);
    push_op(OP_LOAD, 3'd0, 12'h010, 4'h1, 12'h010, 4'hc, 32'h0);
    push_op(OP_LOAD, 3'd0, 12'h010, 4'h6, 12'h030, 4'h2, 32'h0);
    // committed entries drop out, free only at a committed head
    push_op(OP_COMMIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_LOAD, 3'd0, 12'h010, 4'hc, 12'h010, 4'h1, 32'h0);
    push_op(OP_FREE, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_FREE, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    // uncommitted head survives the free
    push_op(OP_LOAD, 3'd0, 12'h030, 4'h3, 12'h010, 4'h3, 32'h0);
    push_op(OP_COMMIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_COMMIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_COMMIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    // committed entries no longer replay either
    push_op(OP_LOAD, 3'd0, 12'h010, 4'h6, 12'h030, 4'h7, 32'h0);
    push_op(OP_FREE, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_FREE, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    // fill to eight, ninth store dropped
    push_op(OP_STORE, 3'd0, 12'h040, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd3, 12'h000, 4'h0, 12'h000, 4'h0, 32'h3333_4444);
    push_op(OP_LOAD, 3'd0, 12'h040, 4'hf, 12'h040, 4'h3, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h050, 4'h3, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd4, 12'h000, 4'h0, 12'h000, 4'h0, 32'h5555_0004);
    push_op(OP_STORE, 3'd0, 12'h060, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd5, 12'h000, 4'h0, 12'h000, 4'h0, 32'h6666_0005);
    push_op(OP_STORE, 3'd0, 12'h050, 4'hc, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd6, 12'h000, 4'h0, 12'h000, 4'h0, 32'h7777_0006);
    push_op(OP_STORE, 3'd0, 12'h060, 4'h1, 12'h000, 4'h0, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h070, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h070, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h080, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h090, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_LOAD, 3'd0, 12'h090, 4'hf, 12'h050, 4'hf, 32'h0);
    push_op(OP_LOAD, 3'd0, 12'h060, 4'h1, 12'h050, 4'h3, 32'h0);
    push_op(OP_COMMIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_FREE, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_WAIT, 3'd0, 12'h000, 4'h0, 12'h000, 4'h0, 32'h0);
    push_op(OP_STORE, 3'd0, 12'h0a0, 4'hf, 12'h000, 4'h0, 32'h0);
    push_op(OP_DATA, 3'd3, 12'h000, 4'h0, 12'h000, 4'h0, 32'h8888_0003);
    push_op(OP_LOAD, 3'd0, 12'h0a0, 4'hf, 12'h060, 4'hf, 32'h0);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (ops[i]) begin
      step(ops[i]);
    end

    for (int r = 0; r < 40; r++) begin
      op.kind = OP_LOAD;
      op.a0 = addr_pool[2'($random(seed))];
      op.b0 = byte_mask_t'($random(seed));
      op.a1 = addr_pool[2'($random(seed))];
      op.b1 = byte_mask_t'($random(seed));
      step(op);
    end

    op.kind = OP_IDLE;
    step(op);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- stq.f
logic/stq_pkg.sv
logic/stq_alloc.sv
logic/stq_entry.sv
logic/stq_entry_array.sv
logic/stq_fwd_select.sv
logic/stq_top.sv
bench/stq_tb.sv

//--- run.sh
#!/bin/sh
# build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module stq_tb -Mdir obj_dir -f stq.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vstq_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test passed$"; then
  exit 0
fi
echo "pass message not found"
exit 1
